// File: run_sim.sh
#!/bin/sh
# Compile and run the UART debug server testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_dbg_server \
  -f uart_dbg_server.f
./obj_dir/Vtb_uart_dbg_server | tee sim.log
if grep -qx "NO ERRORS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: sim/tb_uart_dbg_server.sv
/*
 * Self-checking testbench for the UART debug server. A serial host model
 * sends commands, replies are captured and compared with a reference model.
 */
`timescale 1ns/1ns

module tb_uart_dbg_server;

  localparam int ClksPerBit = 8;
  localparam int MemBytes   = 256;
  // Several times the serial traffic of all tests plus idle gaps
  localparam int MaxCycles  = 200000;

  logic                    clk;
  logic                    rst_n_i;
  logic                    uart_rx_i;
  logic                    uart_tx_o;
  logic                    exec_valid_o;
  uart_dbg_pkg::dbg_addr_t exec_addr_o;

  logic [7:0]  ref_mem [MemBytes];
  logic [7:0]  exp_q[$];
  logic [7:0]  rx_q[$];
  logic [7:0]  wr_data[$];
  logic [15:0] lfsr_q = 16'd45;
  int          err_cnt, err_mark, check_cnt, test_cnt, exec_cnt, cycle_cnt;

  uart_dbg_server #(
    .ClksPerBit ( ClksPerBit ),
    .MemBytes   ( MemBytes   )
  ) UUT (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .uart_rx_i    ( uart_rx_i    ),
    .uart_tx_o    ( uart_tx_o    ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", MaxCycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (exec_valid_o) exec_cnt++;
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      b[i] = lfsr_q[0];
    end
  endtask

  // One 8N1 frame with bit changes 1 ns after the rising edge
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1 uart_rx_i = frame[i];
      repeat (ClksPerBit - 1) @(posedge clk);
    end
  endtask

  task automatic send_field(input logic [63:0] v);
    for (int i = 0; i < uart_dbg_pkg::DbgFieldBytes; i++) send_byte(v[8*i +: 8]);
  endtask

  // Reply byte from the start edge, sampled mid-bit on the falling clock
  task automatic recv_byte(output logic [7:0] b);
    @(negedge uart_tx_o);
    repeat (ClksPerBit / 2) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      repeat (ClksPerBit) @(negedge clk);
      b[i] = uart_tx_o;
    end
    repeat (ClksPerBit) @(negedge clk);
    assert (uart_tx_o === 1'b1) else begin
      err_cnt++;
      $display("error %0t ns: reply byte has a low stop bit", $time);
    end
  endtask

  // Expected reply is ACK, any read data from the model with wrap, then EOT
  function automatic void expect_reply(input logic [7:0] cmd, input logic [63:0] addr,
                                       input logic [63:0] len);
    logic [7:0] idx;
    exp_q.push_back(uart_dbg_pkg::DbgAck);
    if (cmd == uart_dbg_pkg::DbgCmdRead) begin
      for (int i = 0; i < int'(len); i++) begin
        idx = 8'((addr + 64'(i)) % 64'(MemBytes));
        exp_q.push_back(ref_mem[idx]);
      end
    end
    if (cmd == uart_dbg_pkg::DbgCmdRead || cmd == uart_dbg_pkg::DbgCmdWrite) begin
      exp_q.push_back(uart_dbg_pkg::DbgEot);
    end
  endfunction

  initial begin
    logic [7:0] b;
    @(posedge rst_n_i);
    forever begin
      recv_byte(b);
      rx_q.push_back(b);
    end
  end

  // Compare process
  initial begin
    logic [7:0] got;
    logic [7:0] want;
    forever begin
      while (rx_q.size() == 0) @(negedge clk);
      got = rx_q.pop_front();
      check_cnt++;
      assert (exp_q.size() != 0) else begin
        err_cnt++;
        $display("Unexpected reply byte 0x%02h at %0t ns", got, $time);
      end
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        assert (got == want) else begin
          err_cnt++;
          $display("error %0t ns: reply byte 0x%02h, expected 0x%02h", $time, got, want);
        end
      end
    end
  end

  //////////////////////////////
  // Test sequencing
  //////////////////////////////

  // Wait for all expected bytes, then an idle margin to catch extra ones
  task automatic settle();
    while (exp_q.size() != 0) @(posedge clk);
    repeat (4 * 10 * ClksPerBit) @(posedge clk);
  endtask

  task automatic issue(input logic [7:0] cmd, input logic [63:0] addr,
                       input logic [63:0] len);
    expect_reply(cmd, addr, len);
    send_byte(cmd);
    send_field(addr);
    if (cmd != uart_dbg_pkg::DbgCmdExec) send_field(len);
    if (cmd == uart_dbg_pkg::DbgCmdWrite) begin
      // Data goes out once the ACK is back
      while (exp_q.size() > 1) @(posedge clk);
      foreach (wr_data[i]) begin
        send_byte(wr_data[i]);
        ref_mem[8'((addr + 64'(i)) % 64'(MemBytes))] = wr_data[i];
      end
    end
    settle();
  endtask

  task automatic challenge();
    expect_reply(uart_dbg_pkg::DbgAck, '0, '0);
    send_byte(uart_dbg_pkg::DbgAck);
    settle();
  endtask

  task automatic fill_random(input int n);
    logic [7:0] b;
    wr_data.delete();
    for (int i = 0; i < n; i++) begin
      draw_byte(b);
      wr_data.push_back(b);
    end
  endtask

  task automatic report_test(input string name);
    test_cnt++;
    if (err_cnt == err_mark) $display("test %0s passed", name);
    else $display("test %0s failed with %0d errors", name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  initial begin
    logic [63:0] entry;
    logic [7:0]  b;
    int          exec_mark;
    uart_rx_i = 1'b1;
    rst_n_i   = 1'b1;
    #1 rst_n_i = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n_i = 1'b1;

    for (int i = 0; i < 50; i++) begin
      @(negedge clk);
      check_cnt++;
      assert (uart_tx_o === 1'b1 && exec_valid_o === 1'b0) else begin
        err_cnt++;
        $display("error %0t ns: outputs not idle after reset", $time);
      end
    end
    challenge();
    report_test("reset and ACK challenge");

    fill_random(16);
    issue(uart_dbg_pkg::DbgCmdWrite, 64'h20, 64'd16);
    issue(uart_dbg_pkg::DbgCmdRead, 64'h20, 64'd16);
    report_test("write and read back at 0x20");

    fill_random(8);
    issue(uart_dbg_pkg::DbgCmdWrite, 64'h1FC, 64'd8);
    issue(uart_dbg_pkg::DbgCmdRead, 64'd252, 64'd8);
    report_test("address wrap");

    issue(uart_dbg_pkg::DbgCmdRead, 64'h40, 64'd0);
    report_test("zero length read");

    for (int i = 0; i < 8; i++) begin
      draw_byte(b);
      entry[8*i +: 8] = b;
    end
    exec_mark = exec_cnt;
    issue(uart_dbg_pkg::DbgCmdExec, entry, '0);
    check_cnt++;
    assert (exec_cnt == exec_mark + 1 && exec_addr_o == entry) else begin
      err_cnt++;
      $display("error %0t ns: %0d exec pulses, entry 0x%016h, expected 0x%016h",
               $time, exec_cnt - exec_mark, exec_addr_o, entry);
    end
    report_test("exec");

    // Non-command bytes in idle, then a quiet period of 30 bit times
    send_byte(8'h55);
    send_byte(8'h00);
    repeat (30 * ClksPerBit) @(posedge clk);
    challenge();
    report_test("ignored idle bytes");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: src/uart_dbg_engine.sv
/*
 * Debug protocol engine. Decodes ACK challenge, read, write and exec
 * commands from received bytes and serves them from a local byte memory.
 */
`timescale 1ns/1ns

module uart_dbg_engine #(
  parameter int MemBytes = 256
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  uart_dbg_pkg::uart_byte_t rx_byte_i,
  input  logic                    tx_busy_i,
  output uart_dbg_pkg::uart_byte_t tx_byte_o,
  output logic                    exec_valid_o,
  output uart_dbg_pkg::dbg_addr_t  exec_addr_o
);

  localparam int AddrBits = $clog2(MemBytes);
  localparam int CntBits  = $clog2(uart_dbg_pkg::DbgFieldBytes);

  typedef enum logic [2:0] {
    EngIdle,
    EngAddr,
    EngLen,
    EngAck,
    EngData,
    EngEot,
    EngExecAck
  } eng_state_e;

  eng_state_e              state_q;
  logic [7:0]              cmd_q;
  logic [CntBits-1:0]      cnt_q;
  uart_dbg_pkg::dbg_addr_t addr_q;
  uart_dbg_pkg::dbg_addr_t len_q;
  uart_dbg_pkg::dbg_addr_t exec_addr_q;
  logic [7:0]              mem [MemBytes];

  logic is_read;
  logic field_last;
  logic data_step;

  assign is_read    = (cmd_q == uart_dbg_pkg::DbgCmdRead);
  assign field_last = rx_byte_i.valid &&
                      (cnt_q == CntBits'(uart_dbg_pkg::DbgFieldBytes - 1));
  // Reads advance on each byte handed to the transmitter, writes on each byte received
  assign data_step  = (state_q == EngData) && (is_read ? !tx_busy_i : rx_byte_i.valid);

  //////////////////////////////
  // Command FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= EngIdle;
      cmd_q       <= '0;
      cnt_q       <= '0;
      exec_addr_q <= '0;
    end else begin
      case (state_q)
        EngIdle: begin
          cnt_q <= '0;
          if (rx_byte_i.valid) begin
            case (rx_byte_i.data)
              uart_dbg_pkg::DbgAck: begin
                cmd_q   <= rx_byte_i.data;
                state_q <= EngAck;
              end
              uart_dbg_pkg::DbgCmdRead,
              uart_dbg_pkg::DbgCmdWrite,
              uart_dbg_pkg::DbgCmdExec: begin
                cmd_q   <= rx_byte_i.data;
                state_q <= EngAddr;
              end
              default: ;
            endcase
          end
        end
        EngAddr: begin
          if (rx_byte_i.valid) cnt_q <= cnt_q + 1'b1;
          if (field_last) begin
            cnt_q <= '0;
            if (cmd_q == uart_dbg_pkg::DbgCmdExec) begin
              exec_addr_q <= {rx_byte_i.data, addr_q[63:8]};
              state_q     <= EngExecAck;
            end else begin
              state_q <= EngLen;
            end
          end
        end
        EngLen: begin
          if (rx_byte_i.valid) cnt_q <= cnt_q + 1'b1;
          if (field_last) begin
            cnt_q   <= '0;
            state_q <= EngAck;
          end
        end
        EngAck: begin
          if (!tx_busy_i) begin
            if (cmd_q == uart_dbg_pkg::DbgAck) state_q <= EngIdle;
            else if (len_q == '0)              state_q <= EngEot;
            else                               state_q <= EngData;
          end
        end
        EngData: begin
          if (data_step && len_q == 64'd1) state_q <= EngEot;
        end
        EngEot: begin
          if (!tx_busy_i) state_q <= EngIdle;
        end
        default: begin
          if (!tx_busy_i) state_q <= EngIdle;
        end
      endcase
    end
  end

  // Field assembly, least significant byte first, and the running counters
  always_ff @(posedge clk) begin
    if (state_q == EngAddr && rx_byte_i.valid) begin
      addr_q <= {rx_byte_i.data, addr_q[63:8]};
    end else if (state_q == EngLen && rx_byte_i.valid) begin
      len_q <= {rx_byte_i.data, len_q[63:8]};
    end else if (data_step) begin
      addr_q <= addr_q + 1'b1;
      len_q  <= len_q - 1'b1;
    end
  end

  //////////////////////////////
  // Byte memory
  //////////////////////////////

  // Only the low address bits index, so the address wraps on its own
  always_ff @(posedge clk) begin
    if (data_step && !is_read) mem[addr_q[AddrBits-1:0]] <= rx_byte_i.data;
  end

  // Reply byte select
  always_comb begin
    tx_byte_o = '0;
    case (state_q)
      EngAck, EngExecAck: tx_byte_o.data = uart_dbg_pkg::DbgAck;
      EngEot:             tx_byte_o.data = uart_dbg_pkg::DbgEot;
      EngData:            tx_byte_o.data = mem[addr_q[AddrBits-1:0]];
      default:            tx_byte_o.data = '0;
    endcase
    tx_byte_o.valid = !tx_busy_i &&
                      (state_q == EngAck || state_q == EngExecAck || state_q == EngEot ||
                       (state_q == EngData && is_read));
  end

  assign exec_valid_o = (state_q == EngExecAck) && !tx_busy_i;
  assign exec_addr_o  = exec_addr_q;

endmodule

// File: src/uart_dbg_pkg.sv
/*
 * Shared types and protocol constants for the UART debug server.
 * Referenced by scoped name from the RTL and the testbench.
 */
package uart_dbg_pkg;

  //////////////////////////////
  // Byte strobe
  //////////////////////////////

  // One byte on a single-cycle valid strobe
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } uart_byte_t;

  // Address or length field as assembled from the line
  typedef logic [63:0] dbg_addr_t;

  //////////////////////////////
  // Protocol byte codes
  //////////////////////////////

  localparam logic [7:0] DbgCmdRead  = 8'h11;
  localparam logic [7:0] DbgCmdWrite = 8'h12;
  localparam logic [7:0] DbgCmdExec  = 8'h13;
  localparam logic [7:0] DbgAck      = 8'h06;
  localparam logic [7:0] DbgEot      = 8'h04;

  // Bytes per address or length field, least significant first
  localparam int DbgFieldBytes = 8;

endpackage

// File: src/uart_dbg_rx.sv
/*
 * 8N1 UART receiver. Samples each bit in its middle and strobes
 * the byte for one cycle once the stop bit checks out high.
 */
`timescale 1ns/1ns

module uart_dbg_rx #(
  parameter int ClksPerBit = 8
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  logic                    rx_i,
  output uart_dbg_pkg::uart_byte_t byte_o
);

  localparam int CntBits = $clog2(ClksPerBit);

  typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rx_state_e;

  rx_state_e           state_q;
  logic [CntBits-1:0]  cnt_q;
  logic [2:0]          bit_cnt_q;
  logic                rx_meta_q, rx_sync_q, rx_prev_q;
  logic                valid_q;
  logic [7:0]          data_q;
  logic                bit_end;

  assign bit_end = (cnt_q == CntBits'(ClksPerBit - 1));

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= RxIdle;
      cnt_q     <= '0;
      bit_cnt_q <= '0;
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_prev_q <= 1'b1;
      valid_q   <= 1'b0;
    end else begin
      // Two-flop synchronizer plus one stage for edge detection
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_prev_q <= rx_sync_q;
      valid_q   <= 1'b0;
      case (state_q)
        RxIdle: begin
          cnt_q <= '0;
          if (rx_prev_q && !rx_sync_q) state_q <= RxStart;
        end
        RxStart: begin
          // Confirm start bit at half a bit time, then realign to mid-bit
          if (cnt_q == CntBits'(ClksPerBit / 2 - 1)) begin
            cnt_q     <= '0;
            bit_cnt_q <= '0;
            state_q   <= rx_sync_q ? RxIdle : RxData;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RxData: begin
          if (bit_end) begin
            cnt_q     <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) state_q <= RxStop;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          // A low stop bit is a framing error and drops the byte
          if (bit_end) begin
            valid_q <= rx_sync_q;
            state_q <= RxIdle;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge clk) begin
    if (state_q == RxData && bit_end) data_q <= {rx_sync_q, data_q[7:1]};
  end

  assign byte_o.valid = valid_q;
  assign byte_o.data  = data_q;

endmodule

// File: src/uart_dbg_server.sv
/*
 * UART debug server top level. Receiver and transmitter sit side by
 * side and the command engine ties them together.
 */
`timescale 1ns/1ns

module uart_dbg_server #(
  parameter int ClksPerBit = 8,
  parameter int MemBytes   = 256
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   uart_rx_i,
  output logic                   uart_tx_o,
  output logic                   exec_valid_o,
  output uart_dbg_pkg::dbg_addr_t exec_addr_o
);

  uart_dbg_pkg::uart_byte_t rx_byte;
  uart_dbg_pkg::uart_byte_t tx_byte;
  logic                     tx_busy;

  uart_dbg_rx #(
    .ClksPerBit ( ClksPerBit )
  ) i_rx (
    .clk     ( clk       ),
    .rst_n_i ( rst_n_i   ),
    .rx_i    ( uart_rx_i ),
    .byte_o  ( rx_byte   )
  );

  uart_dbg_tx #(
    .ClksPerBit ( ClksPerBit )
  ) i_tx (
    .clk     ( clk       ),
    .rst_n_i ( rst_n_i   ),
    .byte_i  ( tx_byte   ),
    .busy_o  ( tx_busy   ),
    .tx_o    ( uart_tx_o )
  );

  uart_dbg_engine #(
    .MemBytes ( MemBytes )
  ) i_engine (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .rx_byte_i    ( rx_byte      ),
    .tx_busy_i    ( tx_busy      ),
    .tx_byte_o    ( tx_byte      ),
    .exec_valid_o ( exec_valid_o ),
    .exec_addr_o  ( exec_addr_o  )
  );

endmodule

// File: src/uart_dbg_tx.sv
/*
 * 8N1 UART transmitter. A strobe while idle loads one frame and the
 * line is driven straight from the low end of the frame register.
 */
`timescale 1ns/1ns

module uart_dbg_tx #(
  parameter int ClksPerBit = 8
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  uart_dbg_pkg::uart_byte_t byte_i,
  output logic                    busy_o,
  output logic                    tx_o
);

  localparam int CntBits = $clog2(ClksPerBit);

  logic [9:0]         frame_q;
  logic [CntBits-1:0] cnt_q;
  logic [3:0]         bits_left_q;
  logic               busy_q;
  logic               tick;

  assign tick = (cnt_q == CntBits'(ClksPerBit - 1));

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      frame_q     <= '1;
      cnt_q       <= '0;
      bits_left_q <= '0;
      busy_q      <= 1'b0;
    end else if (!busy_q) begin
      // Stop bit, data LSB first, start bit at bit 0
      if (byte_i.valid) begin
        frame_q     <= {1'b1, byte_i.data, 1'b0};
        cnt_q       <= '0;
        bits_left_q <= 4'd9;
        busy_q      <= 1'b1;
      end
    end else if (tick) begin
      cnt_q <= '0;
      if (bits_left_q == '0) begin
        // End of stop bit
        busy_q <= 1'b0;
      end else begin
        frame_q     <= {1'b1, frame_q[9:1]};
        bits_left_q <= bits_left_q - 1'b1;
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign busy_o = busy_q;
  assign tx_o   = frame_q[0];

endmodule

// File: uart_dbg_server.f
src/uart_dbg_pkg.sv
src/uart_dbg_rx.sv
src/uart_dbg_tx.sv
src/uart_dbg_engine.sv
src/uart_dbg_server.sv
sim/tb_uart_dbg_server.sv
